// ==== common/serial_link_pkg.sv ====
// Sizes are fixed at compile time; every derived width assumes NumCredits and MaxClkDiv stay small
package serial_link_pkg;

  // Link sizes
  localparam int FlitDataSize = 32;
  localparam int NumLanes     = 4;
  localparam int PhyWordBits  = 2 * NumLanes;
  localparam int NumCredits   = 4;
  localparam int CreditBits   = $clog2(NumCredits + 1);
  localparam int MaxClkDiv    = 16;
  localparam int ClkDivBits   = $clog2(MaxClkDiv + 1);

  // One flit as it travels through the link
  typedef struct packed {
    logic                    hdr;
    logic [FlitDataSize-1:0] flit_data;
  } payload_t;

  // Frame layout, padded up to a whole number of physical words
  localparam int FrameUsedBits = 1 + CreditBits + $bits(payload_t);
  localparam int WordsPerFrame = (FrameUsedBits + PhyWordBits - 1) / PhyWordBits;
  localparam int FrameBits     = WordsPerFrame * PhyWordBits;
  localparam int FramePadBits  = FrameBits - FrameUsedBits;
  localparam int WordCntBits   = $clog2(WordsPerFrame);

  // Frame kinds
  localparam logic KindCredit = 1'b0;
  localparam logic KindData   = 1'b1;

  typedef logic [PhyWordBits-1:0] phy_word_t;

  // Kind sits in bit 0, so it leaves with the first (lowest) word
  typedef struct packed {
    logic [FramePadBits-1:0] pad;
    payload_t                payload;
    logic [CreditBits-1:0]   credits;
    logic                    kind;
  } frame_t;

endpackage

// ==== hdl/stream_fifo.sv ====
// Push and pop may share a cycle; a full FIFO refuses a push even when it pops in the same cycle
`timescale 1ns/10ps

module stream_fifo #(
  parameter type data_t = logic,
  parameter int  Depth  = 2
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  data_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output data_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntBits = $clog2(Depth + 1);

  data_t              mem [Depth];
  logic [PtrBits-1:0] wr_ptr_q;
  logic [PtrBits-1:0] rd_ptr_q;
  logic [CntBits-1:0] count_q;
  logic               push;
  logic               pop;

  assign ready_o = (count_q != CntBits'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrBits'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrBits'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== data_link/link_frame_tx.sv ====
// Holds one frame at a time; a flit is taken only with a credit in hand and no frame in flight
`timescale 1ns/10ps

module link_frame_tx
  import serial_link_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [FlitDataSize-1:0] flit_i,
  input  logic                    flit_hdr_i,
  input  logic                    flit_valid_i,
  output logic                    flit_ready_o,
  input  logic [CreditBits-1:0]   pending_credits_i,
  output logic                    credits_sent_o,
  input  logic [CreditBits-1:0]   credits_in_i,
  input  logic                    credits_in_valid_i,
  output phy_word_t               word_o,
  output logic                    word_valid_o,
  input  logic                    word_ready_i
);

  logic [CreditBits-1:0]  credits_q;
  logic [CreditBits-1:0]  credits_add;
  logic [WordCntBits-1:0] word_cnt_q;
  logic                   sending_q;
  frame_t                 frame_q;
  frame_t                 frame_d;
  logic                   flit_accept;
  logic                   credit_load;
  logic                   frame_load;
  logic                   word_done;

  ////////////////////
  // Frame selection
  ////////////////////

  assign flit_ready_o = !sending_q && (credits_q != '0);
  assign flit_accept  = flit_valid_i && flit_ready_o;

  // Credit-only frame when there is something to report and no flit goes out
  assign credit_load = !sending_q && !flit_accept && (pending_credits_i != '0);
  assign frame_load  = flit_accept || credit_load;

  // Every frame carries the pending count, so any load reports it
  assign credits_sent_o = frame_load;

  always_comb begin
    frame_d                   = '0;
    frame_d.kind              = flit_accept ? KindData : KindCredit;
    frame_d.credits           = pending_credits_i;
    if (flit_accept) begin
      frame_d.payload.hdr       = flit_hdr_i;
      frame_d.payload.flit_data = flit_i;
    end
  end

  ////////////////////
  // Credit counter
  ////////////////////

  assign credits_add = credits_in_valid_i ? credits_in_i : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q <= CreditBits'(NumCredits);
    end else begin
      credits_q <= credits_q + credits_add - CreditBits'(flit_accept);
    end
  end

  ////////////////////
  // Word shifter
  ////////////////////

  assign word_o       = frame_q[PhyWordBits-1:0];
  assign word_valid_o = sending_q;
  assign word_done    = sending_q && word_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sending_q  <= 1'b0;
      word_cnt_q <= '0;
    end else if (frame_load) begin
      sending_q  <= 1'b1;
      word_cnt_q <= '0;
    end else if (word_done) begin
      word_cnt_q <= word_cnt_q + 1'b1;
      if (word_cnt_q == WordCntBits'(WordsPerFrame - 1)) begin
        sending_q <= 1'b0;
      end
    end
  end

  // Frame register, shifted down one word at a time
  always_ff @(posedge clk_i) begin
    if (frame_load) begin
      frame_q <= frame_d;
    end else if (word_done) begin
      frame_q <= frame_t'(frame_q >> PhyWordBits);
    end
  end

endmodule

// ==== data_link/link_frame_rx.sv ====
// Word alignment relies on both ends leaving reset together; no resync after a lost word
`timescale 1ns/10ps

module link_frame_rx
  import serial_link_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  phy_word_t               word_i,
  input  logic                    word_valid_i,
  output logic [CreditBits-1:0]   credits_in_o,
  output logic                    credits_in_valid_o,
  output logic [CreditBits-1:0]   pending_credits_o,
  input  logic                    credits_sent_i,
  output logic [FlitDataSize-1:0] flit_o,
  output logic                    flit_hdr_o,
  output logic                    flit_valid_o,
  input  logic                    flit_ready_i
);

  logic [WordCntBits-1:0] word_cnt_q;
  logic [FrameBits-1:0]   gather_q;
  frame_t                 frame_full;
  logic                   frame_last;
  logic                   push_valid;
  payload_t               fifo_out;
  logic                   pop;
  logic [CreditBits-1:0]  pending_q;
  logic [CreditBits-1:0]  pending_base;

  ////////////////////
  // Frame gathering
  ////////////////////

  // Words arrive lowest first, so each new one enters at the top
  assign frame_full = frame_t'({word_i, gather_q[FrameBits-1:PhyWordBits]});
  assign frame_last = word_valid_i && (word_cnt_q == WordCntBits'(WordsPerFrame - 1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_cnt_q <= '0;
    end else if (word_valid_i) begin
      word_cnt_q <= frame_last ? '0 : word_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_valid_i) begin
      gather_q <= frame_full;
    end
  end

  assign credits_in_o       = frame_full.credits;
  assign credits_in_valid_o = frame_last;
  assign push_valid         = frame_last && (frame_full.kind == KindData);

  ////////////////////
  // Receive FIFO
  ////////////////////

  // Room is guaranteed by the credits, so the ready output stays open
  stream_fifo #(
    .data_t  ( payload_t  ),
    .Depth   ( NumCredits )
  ) i_rx_fifo (
    .clk_i   ( clk_i              ),
    .rst_n_i ( rst_n_i            ),
    .data_i  ( frame_full.payload ),
    .valid_i ( push_valid         ),
    .ready_o (                    ),
    .data_o  ( fifo_out           ),
    .valid_o ( flit_valid_o       ),
    .ready_i ( flit_ready_i       )
  );

  assign flit_o     = fifo_out.flit_data;
  assign flit_hdr_o = fifo_out.hdr;
  assign pop        = flit_valid_o && flit_ready_i;

  // Freed slots wait here until the tx side ships them
  assign pending_base      = credits_sent_i ? '0 : pending_q;
  assign pending_credits_o = pending_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_base + CreditBits'(pop);
    end
  end

endmodule

// ==== physical/serial_link_phy_tx.sv ====
// clk_div_i must be even, at least 4, and stable while a word is on the lanes
`timescale 1ns/10ps

module serial_link_phy_tx
  import serial_link_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [ClkDivBits-1:0] clk_div_i,
  input  phy_word_t             word_i,
  input  logic                  word_valid_i,
  output logic                  word_ready_o,
  output logic [NumLanes-1:0]   ddr_o,
  output logic                  ddr_rcv_clk_o
);

  phy_word_t             fifo_word;
  logic                  fifo_valid;
  logic                  fifo_pop;
  phy_word_t             word_q;
  logic                  active_q;
  logic                  half_q;
  logic                  clk_q;
  logic [ClkDivBits-1:0] cnt_q;
  logic [ClkDivBits-1:0] div_last;
  logic [ClkDivBits-1:0] div_mid;
  logic                  half_end;
  logic                  word_end;

  // Lets the framer run one word ahead of the lanes
  stream_fifo #(
    .data_t  ( phy_word_t ),
    .Depth   ( 2          )
  ) i_word_fifo (
    .clk_i   ( clk_i        ),
    .rst_n_i ( rst_n_i      ),
    .data_i  ( word_i       ),
    .valid_i ( word_valid_i ),
    .ready_o ( word_ready_o ),
    .data_o  ( fifo_word    ),
    .valid_o ( fifo_valid   ),
    .ready_i ( fifo_pop     )
  );

  assign div_last = clk_div_i - 1'b1;
  assign div_mid  = (clk_div_i >> 1) - 1'b1;
  assign half_end = active_q && (cnt_q == div_last);
  assign word_end = half_end && half_q;

  // Next word follows the last one without a gap
  assign fifo_pop = fifo_valid && (!active_q || word_end);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      half_q   <= 1'b0;
      cnt_q    <= '0;
      clk_q    <= 1'b0;
    end else begin
      // Forwarded clock flips halfway through each half
      if (active_q && (cnt_q == div_mid)) begin
        clk_q <= ~clk_q;
      end
      if (fifo_pop) begin
        active_q <= 1'b1;
        half_q   <= 1'b0;
        cnt_q    <= '0;
      end else if (half_end) begin
        cnt_q  <= '0;
        half_q <= 1'b1;
        if (half_q) begin
          active_q <= 1'b0;
        end
      end else if (active_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop) begin
      word_q <= fifo_word;
    end
  end

  // Low half first, lanes idle at zero
  assign ddr_o = !active_q ? '0 :
                 half_q    ? word_q[PhyWordBits-1:NumLanes] : word_q[NumLanes-1:0];
  assign ddr_rcv_clk_o = clk_q;

endmodule

// ==== physical/serial_link_phy_rx.sv ====
// Received clock must be slower than clk_i by the clk_div_i rules; lanes and clock see equal delay
`timescale 1ns/10ps

module serial_link_phy_rx
  import serial_link_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NumLanes-1:0] ddr_i,
  input  logic                ddr_rcv_clk_i,
  output phy_word_t           word_o,
  output logic                word_valid_o
);

  // Clock sits on top, lanes below, so both take the same path
  logic [NumLanes:0]   sync_q1;
  logic [NumLanes:0]   sync_q2;
  logic                clk_prev_q;
  logic                rcv_clk;
  logic                clk_rise;
  logic                clk_fall;
  logic [NumLanes-1:0] low_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1    <= '0;
      sync_q2    <= '0;
      clk_prev_q <= 1'b0;
    end else begin
      sync_q1    <= {ddr_rcv_clk_i, ddr_i};
      sync_q2    <= sync_q1;
      clk_prev_q <= sync_q2[NumLanes];
    end
  end

  assign rcv_clk  = sync_q2[NumLanes];
  assign clk_rise = rcv_clk && !clk_prev_q;
  assign clk_fall = !rcv_clk && clk_prev_q;

  // Low half on rise, whole word on fall
  always_ff @(posedge clk_i) begin
    if (clk_rise) begin
      low_q <= sync_q2[NumLanes-1:0];
    end
    if (clk_fall) begin
      word_o <= {sync_q2[NumLanes-1:0], low_q};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= clk_fall;
    end
  end

endmodule

// ==== hdl/serial_link.sv ====
// One channel, one clock domain; the far end must use the same package sizes and leave reset together
`timescale 1ns/10ps

module serial_link
  import serial_link_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [ClkDivBits-1:0]   clk_div_i,
  // Flits into the link
  input  logic [FlitDataSize-1:0] flit_i,
  input  logic                    flit_hdr_i,
  input  logic                    flit_valid_i,
  output logic                    flit_ready_o,
  // Flits out of the link
  output logic [FlitDataSize-1:0] flit_o,
  output logic                    flit_hdr_o,
  output logic                    flit_valid_o,
  input  logic                    flit_ready_i,
  // Lanes
  input  logic [NumLanes-1:0]     ddr_i,
  input  logic                    ddr_rcv_clk_i,
  output logic [NumLanes-1:0]     ddr_o,
  output logic                    ddr_rcv_clk_o
);

  phy_word_t             tx_word;
  logic                  tx_word_valid;
  logic                  tx_word_ready;
  phy_word_t             rx_word;
  logic                  rx_word_valid;
  logic [CreditBits-1:0] credits_in;
  logic                  credits_in_valid;
  logic [CreditBits-1:0] pending_credits;
  logic                  credits_sent;

  ////////////////////
  // Data link
  ////////////////////

  link_frame_tx i_frame_tx (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .flit_i             ( flit_i           ),
    .flit_hdr_i         ( flit_hdr_i       ),
    .flit_valid_i       ( flit_valid_i     ),
    .flit_ready_o       ( flit_ready_o     ),
    .pending_credits_i  ( pending_credits  ),
    .credits_sent_o     ( credits_sent     ),
    .credits_in_i       ( credits_in       ),
    .credits_in_valid_i ( credits_in_valid ),
    .word_o             ( tx_word          ),
    .word_valid_o       ( tx_word_valid    ),
    .word_ready_i       ( tx_word_ready    )
  );

  link_frame_rx i_frame_rx (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .word_i             ( rx_word          ),
    .word_valid_i       ( rx_word_valid    ),
    .credits_in_o       ( credits_in       ),
    .credits_in_valid_o ( credits_in_valid ),
    .pending_credits_o  ( pending_credits  ),
    .credits_sent_i     ( credits_sent     ),
    .flit_o             ( flit_o           ),
    .flit_hdr_o         ( flit_hdr_o       ),
    .flit_valid_o       ( flit_valid_o     ),
    .flit_ready_i       ( flit_ready_i     )
  );

  ////////////////////
  // Physical layer
  ////////////////////

  serial_link_phy_tx i_phy_tx (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .clk_div_i     ( clk_div_i     ),
    .word_i        ( tx_word       ),
    .word_valid_i  ( tx_word_valid ),
    .word_ready_o  ( tx_word_ready ),
    .ddr_o         ( ddr_o         ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o )
  );

  serial_link_phy_rx i_phy_rx (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .ddr_i         ( ddr_i         ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .word_o        ( rx_word       ),
    .word_valid_o  ( rx_word_valid )
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
// Free-running clock from time zero; reset releases on a falling edge after ResetCycles cycles
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int ClkPeriod   = 10,
  parameter int ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== verification/tb_serial_link.sv ====
// Lanes and forwarded clock loop back with no delay; the first failed check ends the run
`timescale 1ns/10ps

module tb_serial_link
  import serial_link_pkg::*;
();

  // About 40 flits at 2*8*5 cycles each, credit frames and the blocked phase, with margin
  localparam int TimeoutCycles = 20000;
  localparam int StreamFlits   = 20;
  localparam int OfferedFlits  = 10;
  localparam int BlockCycles   = 1000;
  localparam int SettleCycles  = 200;

  logic                    clk;
  logic                    rst_n;
  logic [ClkDivBits-1:0]   clk_div;
  logic [FlitDataSize-1:0] flit_in;
  logic                    flit_hdr_in;
  logic                    flit_valid_in;
  logic                    flit_ready_out;
  logic [FlitDataSize-1:0] flit_out;
  logic                    flit_hdr_out;
  logic                    flit_valid_out;
  logic                    flit_ready_in;
  logic [NumLanes-1:0]     lanes;
  logic                    lane_clk;
  logic [FlitDataSize:0]   exp_q [$];
  logic [FlitDataSize:0]   exp_flit;
  int                      accepted_cnt;
  int                      cycle_cnt;
  integer                  seed;

  tb_clock_gen #(
    .ClkPeriod   ( 10 ),
    .ResetCycles ( 5  )
  ) i_clock_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  serial_link UUT (
    .clk_i         ( clk            ),
    .rst_n_i       ( rst_n          ),
    .clk_div_i     ( clk_div        ),
    .flit_i        ( flit_in        ),
    .flit_hdr_i    ( flit_hdr_in    ),
    .flit_valid_i  ( flit_valid_in  ),
    .flit_ready_o  ( flit_ready_out ),
    .flit_o        ( flit_out       ),
    .flit_hdr_o    ( flit_hdr_out   ),
    .flit_valid_o  ( flit_valid_out ),
    .flit_ready_i  ( flit_ready_in  ),
    .ddr_i         ( lanes          ),
    .ddr_rcv_clk_i ( lane_clk       ),
    .ddr_o         ( lanes          ),
    .ddr_rcv_clk_o ( lane_clk       )
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
      $display("Test failures found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Holds valid until the link takes the flit; ready does not depend on valid
  task automatic send_flit(input logic [FlitDataSize-1:0] data, input logic hdr);
    @(negedge clk);
    flit_in       = data;
    flit_hdr_in   = hdr;
    flit_valid_in = 1'b1;
    while (!flit_ready_out) @(negedge clk);
    exp_q.push_back({hdr, data});
    accepted_cnt++;
    @(negedge clk);
    flit_valid_in = 1'b0;
  endtask

  // Header drawn on its own so it is not tied to any data bit
  task automatic send_random_flit();
    logic [31:0] rnd_data;
    logic [31:0] rnd_hdr;
    rnd_data = $random(seed);
    rnd_hdr  = $random(seed);
    send_flit(FlitDataSize'(rnd_data), rnd_hdr[0]);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // Lets trailing credit frames finish so the link is idle
  task automatic settle();
    repeat (SettleCycles) @(negedge clk);
  endtask

  // Counts cycles between rises of the forwarded clock over one frame
  task automatic measure_rises(input int div);
    int   cycles;
    int   last_rise;
    int   rises;
    logic prev;
    cycles    = 0;
    last_rise = 0;
    rises     = 0;
    prev      = lane_clk;
    while (rises < WordsPerFrame) begin
      @(posedge clk);
      cycles++;
      if (lane_clk && !prev) begin
        if (rises > 0) begin
          check_value(64'(cycles - last_rise), 64'(2 * div), "forwarded clock period");
        end
        last_rise = cycles;
        rises++;
      end
      prev = lane_clk;
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    check_value(64'(flit_valid_out), 64'd0, "flit_valid_o after reset");
    check_value(64'(lanes), 64'd0, "ddr_o after reset");
    check_value(64'(lane_clk), 64'd0, "ddr_rcv_clk_o after reset");
    check_value(64'(flit_ready_out), 64'd1, "flit_ready_o after reset");
  endtask

  task automatic test_single_flit();
    clk_div = ClkDivBits'(4);
    send_flit(32'hA5C3_0F01, 1'b1);
    wait_drain();
  endtask

  task automatic test_stream();
    flit_ready_in = 1'b1;
    repeat (StreamFlits) send_random_flit();
    wait_drain();
  endtask

  task automatic test_backpressure();
    int start_cnt;
    int i;
    settle();
    check_value(64'(flit_ready_out), 64'd1, "credits back before back-pressure");
    flit_ready_in = 1'b0;
    start_cnt     = accepted_cnt;
    fork
      begin
        for (i = 0; i < OfferedFlits; i++) begin
          send_random_flit();
        end
      end
      begin
        repeat (BlockCycles) @(negedge clk);
        check_value(64'(accepted_cnt - start_cnt), 64'(NumCredits), "flits taken while blocked");
        check_value(64'(flit_ready_out), 64'd0, "flit_ready_o while blocked");
        flit_ready_in = 1'b1;
      end
    join
    wait_drain();
  endtask

  task automatic test_clk_div(input int div);
    settle();
    clk_div = ClkDivBits'(div);
    fork
      send_random_flit();
      measure_rises(div);
    join
    wait_drain();
  endtask

  ////////////////////
  // Output monitor and timeout
  ////////////////////

  // Sampled on the rising edge, where the transfer itself happens
  always @(posedge clk) begin
    if (rst_n && flit_valid_out && flit_ready_in) begin
      if (exp_q.size() == 0) begin
        $display("A flit came out of the link although none was sent");
        $display("Test failures found");
        $fatal(1, "Unexpected output flit");
      end else begin
        exp_flit = exp_q.pop_front();
        check_value(64'(flit_out), 64'(exp_flit[FlitDataSize-1:0]), "flit data");
        check_value(64'(flit_hdr_out), 64'(exp_flit[FlitDataSize]), "flit header");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("The run took longer than %0d cycles and was stopped", TimeoutCycles);
      $display("Test failures found");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    seed          = 54;
    cycle_cnt     = 0;
    accepted_cnt  = 0;
    clk_div       = ClkDivBits'(4);
    flit_in       = '0;
    flit_hdr_in   = 1'b0;
    flit_valid_in = 1'b0;
    flit_ready_in = 1'b1;
    @(posedge rst_n);
    @(negedge clk);
    test_reset();
    test_single_flit();
    test_stream();
    test_backpressure();
    test_clk_div(4);
    test_clk_div(8);
    if (exp_q.size() != 0) begin
      $display("%0d flits never came back", exp_q.size());
      $display("Test failures found");
      $fatal(1, "Missing flits");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
common/serial_link_pkg.sv
hdl/stream_fifo.sv
data_link/link_frame_tx.sv
data_link/link_frame_rx.sv
physical/serial_link_phy_tx.sv
physical/serial_link_phy_rx.sv
hdl/serial_link.sv
verification/tb_clock_gen.sv
verification/tb_serial_link.sv

// ==== Makefile ====
# Verilator build for the serial link loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_link
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
